//--- include/ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// data path widths
`define NB_BITS      32
`define NB_REG       5
`define NB_FUNCTION  6
`define NB_ALU_OP    4

// data memory depth in words
`define DMEM_WORDS   64
`define RETURN_REG   31  // link register

`endif

//--- rtl/ex_ctl_pkg.sv
`include "ex_macros.svh"

package ex_ctl_pkg;

   // operation class from the decoder
   typedef enum logic [`NB_ALU_OP-1:0] {
      ALUOP_ADD   = 4'd0,  // loads, stores, addi
      ALUOP_SUB   = 4'd1,
      ALUOP_RTYPE = 4'd2,  // look at function field
      ALUOP_AND   = 4'd3,
      ALUOP_OR    = 4'd4,
      ALUOP_XOR   = 4'd5,
      ALUOP_SLT   = 4'd6,
      ALUOP_LUI   = 4'd7
   } alu_op_t;

   typedef enum logic [`NB_FUNCTION-1:0] {
      FN_SLL = 6'd0,  FN_SRL = 6'd2,  FN_SRA = 6'd3,
      FN_ADD = 6'd32, FN_SUB = 6'd34, FN_AND = 6'd36,
      FN_OR  = 6'd37, FN_XOR = 6'd38, FN_NOR = 6'd39,
      FN_SLT = 6'd42
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_sel_t;

   typedef enum logic [1:0] {PC_TO_A, RS_TO_A, SEXT_TO_A} src_a_t;
   typedef enum logic {RT_TO_B, SEXT_TO_B} src_b_t;
   typedef enum logic [1:0] {DEST_FROM_RD, DEST_FROM_RT, DEST_TO_RETURN} dest_t;
   typedef enum logic [1:0] {FROM_ID_EX, FROM_EX_MEM, FROM_MEM_WB} fwd_t;

   typedef struct packed {
      logic reg_write;
      logic mem_to_reg;  // write back the loaded word
   } wb_ctl_t;

   typedef struct packed {
      logic mem_read;
      logic mem_write;
   } mem_ctl_t;

endpackage

//--- rtl/ex_data_pkg.sv
`include "ex_macros.svh"

package ex_data_pkg;

   typedef logic [`NB_BITS-1:0] word_t;
   typedef logic [`NB_REG-1:0]  reg_num_t;

   typedef struct packed {
      ex_ctl_pkg::wb_ctl_t  wb_ctl;
      ex_ctl_pkg::mem_ctl_t mem_ctl;
      word_t                alu_out;
      word_t                store_data;  // forwarded rt
      reg_num_t             reg_dst;
   } ex_mem_t;

   typedef struct packed {
      ex_ctl_pkg::wb_ctl_t wb_ctl;
      reg_num_t            reg_dst;
      word_t               data;  // loaded word or alu result
   } mem_wb_t;

endpackage

//--- rtl/ex_mem_if.sv
`timescale 1ns/1ps

interface ex_mem_if;

   ex_ctl_pkg::wb_ctl_t  wb_ctl;
   ex_ctl_pkg::mem_ctl_t mem_ctl;
   ex_data_pkg::word_t   alu_out;
   ex_data_pkg::word_t   store_data;
   ex_data_pkg::reg_num_t reg_dst;

   // execute stage side
   modport producer (output wb_ctl, output mem_ctl, output alu_out,
                     output store_data, output reg_dst);

   // memory stage side
   modport consumer (input wb_ctl, input mem_ctl, input alu_out,
                     input store_data, input reg_dst);

   // forwarding only needs to know who writes where
   modport monitor (input wb_ctl, input reg_dst);

endinterface

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
   input  ex_data_pkg::word_t   i_data_a,
   input  ex_data_pkg::word_t   i_data_b,
   input  ex_ctl_pkg::alu_sel_t i_sel,
   output ex_data_pkg::word_t   o_result
);

   localparam int NB_HALF = $bits(ex_data_pkg::word_t) / 2;

   logic [4:0] shamt;

   assign shamt = i_data_a[4:0];  // shift amount rides on operand a

   always_comb begin
      case (i_sel)
         ex_ctl_pkg::ALU_ADD: o_result = i_data_a + i_data_b;
         ex_ctl_pkg::ALU_SUB: o_result = i_data_a - i_data_b;
         ex_ctl_pkg::ALU_AND: o_result = i_data_a & i_data_b;
         ex_ctl_pkg::ALU_OR:  o_result = i_data_a | i_data_b;
         ex_ctl_pkg::ALU_XOR: o_result = i_data_a ^ i_data_b;
         ex_ctl_pkg::ALU_NOR: o_result = ~(i_data_a | i_data_b);
         ex_ctl_pkg::ALU_SLT: begin
            o_result = ex_data_pkg::word_t'($signed(i_data_a) < $signed(i_data_b));
         end
         ex_ctl_pkg::ALU_SLL: o_result = i_data_b << shamt;
         ex_ctl_pkg::ALU_SRL: o_result = i_data_b >> shamt;
         ex_ctl_pkg::ALU_SRA: o_result = $signed(i_data_b) >>> shamt;  // keeps sign
         ex_ctl_pkg::ALU_LUI: o_result = {i_data_b[NB_HALF-1:0], {NB_HALF{1'b0}}};
         default:             o_result = i_data_a + i_data_b;
      endcase
   end

endmodule

//--- rtl/alu_control.sv
`timescale 1ns/1ps

module alu_control (
   input  ex_ctl_pkg::alu_op_t  i_alu_op,
   input  ex_ctl_pkg::funct_t   i_function,
   output ex_ctl_pkg::alu_sel_t o_sel
);

   ex_ctl_pkg::alu_sel_t rtype_sel;

   // r-type decode on the function field
   always_comb begin
      case (i_function)
         ex_ctl_pkg::FN_SLL: rtype_sel = ex_ctl_pkg::ALU_SLL;
         ex_ctl_pkg::FN_SRL: rtype_sel = ex_ctl_pkg::ALU_SRL;
         ex_ctl_pkg::FN_SRA: rtype_sel = ex_ctl_pkg::ALU_SRA;
         ex_ctl_pkg::FN_ADD: rtype_sel = ex_ctl_pkg::ALU_ADD;
         ex_ctl_pkg::FN_SUB: rtype_sel = ex_ctl_pkg::ALU_SUB;
         ex_ctl_pkg::FN_AND: rtype_sel = ex_ctl_pkg::ALU_AND;
         ex_ctl_pkg::FN_OR:  rtype_sel = ex_ctl_pkg::ALU_OR;
         ex_ctl_pkg::FN_XOR: rtype_sel = ex_ctl_pkg::ALU_XOR;
         ex_ctl_pkg::FN_NOR: rtype_sel = ex_ctl_pkg::ALU_NOR;
         ex_ctl_pkg::FN_SLT: rtype_sel = ex_ctl_pkg::ALU_SLT;
         default:            rtype_sel = ex_ctl_pkg::ALU_ADD;  // unknown code
      endcase
   end

   always_comb begin
      case (i_alu_op)
         ex_ctl_pkg::ALUOP_ADD:   o_sel = ex_ctl_pkg::ALU_ADD;
         ex_ctl_pkg::ALUOP_SUB:   o_sel = ex_ctl_pkg::ALU_SUB;
         ex_ctl_pkg::ALUOP_RTYPE: o_sel = rtype_sel;
         ex_ctl_pkg::ALUOP_AND:   o_sel = ex_ctl_pkg::ALU_AND;
         ex_ctl_pkg::ALUOP_OR:    o_sel = ex_ctl_pkg::ALU_OR;
         ex_ctl_pkg::ALUOP_XOR:   o_sel = ex_ctl_pkg::ALU_XOR;
         ex_ctl_pkg::ALUOP_SLT:   o_sel = ex_ctl_pkg::ALU_SLT;
         ex_ctl_pkg::ALUOP_LUI:   o_sel = ex_ctl_pkg::ALU_LUI;
         default:                 o_sel = ex_ctl_pkg::ALU_ADD;
      endcase
   end

endmodule

//--- rtl/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit (
   input  ex_data_pkg::reg_num_t i_rs_num,
   input  ex_data_pkg::reg_num_t i_rt_num,
   ex_mem_if.monitor             ex_mem,
   input  ex_data_pkg::mem_wb_t  i_mem_wb,
   output ex_ctl_pkg::fwd_t      o_fwd_a,
   output ex_ctl_pkg::fwd_t      o_fwd_b
);

   // newest pending write wins, r0 never forwarded
   function automatic ex_ctl_pkg::fwd_t pick_src(
      input ex_data_pkg::reg_num_t num,
      input logic                  exm_write,
      input ex_data_pkg::reg_num_t exm_dst,
      input logic                  mwb_write,
      input ex_data_pkg::reg_num_t mwb_dst
   );
      if (exm_write && (exm_dst != '0) && (exm_dst == num))
         return ex_ctl_pkg::FROM_EX_MEM;
      else if (mwb_write && (mwb_dst != '0) && (mwb_dst == num))
         return ex_ctl_pkg::FROM_MEM_WB;
      else
         return ex_ctl_pkg::FROM_ID_EX;
   endfunction

   assign o_fwd_a = pick_src(i_rs_num, ex_mem.wb_ctl.reg_write, ex_mem.reg_dst,
                             i_mem_wb.wb_ctl.reg_write, i_mem_wb.reg_dst);
   assign o_fwd_b = pick_src(i_rt_num, ex_mem.wb_ctl.reg_write, ex_mem.reg_dst,
                             i_mem_wb.wb_ctl.reg_write, i_mem_wb.reg_dst);

endmodule

//--- rtl/ex_stage.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex_stage (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_stall,
   input  ex_ctl_pkg::alu_op_t   i_alu_op,
   input  ex_ctl_pkg::funct_t    i_function,
   input  ex_ctl_pkg::src_a_t    i_src_a_sel,
   input  ex_ctl_pkg::src_b_t    i_src_b_sel,
   input  ex_ctl_pkg::dest_t     i_dest_sel,
   input  ex_ctl_pkg::fwd_t      i_fwd_a,
   input  ex_ctl_pkg::fwd_t      i_fwd_b,
   input  ex_data_pkg::reg_num_t i_rt_num,
   input  ex_data_pkg::reg_num_t i_rd_num,
   input  ex_data_pkg::word_t    i_rs_data,
   input  ex_data_pkg::word_t    i_rt_data,
   input  ex_data_pkg::word_t    i_sign_ext,
   input  ex_data_pkg::word_t    i_pc_4,
   input  ex_ctl_pkg::wb_ctl_t   i_wb_ctl,
   input  ex_ctl_pkg::mem_ctl_t  i_mem_ctl,
   input  ex_data_pkg::word_t    i_wb_fwd,  // value in mem/wb
   ex_mem_if.producer            ex_mem,
   output ex_data_pkg::reg_num_t o_reg_dst
);

   ex_data_pkg::word_t   rs_val, rt_val;
   ex_data_pkg::word_t   data_a, data_b, alu_out;
   ex_ctl_pkg::alu_sel_t alu_sel;
   ex_data_pkg::ex_mem_t ex_mem_q;

   function automatic ex_data_pkg::word_t fwd_mux(
      input ex_ctl_pkg::fwd_t   sel,
      input ex_data_pkg::word_t id_ex_val,
      input ex_data_pkg::word_t ex_mem_val,
      input ex_data_pkg::word_t mem_wb_val
   );
      case (sel)
         ex_ctl_pkg::FROM_EX_MEM: return ex_mem_val;
         ex_ctl_pkg::FROM_MEM_WB: return mem_wb_val;
         default:                 return id_ex_val;
      endcase
   endfunction

   // register values after forwarding, own record gives the ex/mem path
   assign rs_val = fwd_mux(i_fwd_a, i_rs_data, ex_mem.alu_out, i_wb_fwd);
   assign rt_val = fwd_mux(i_fwd_b, i_rt_data, ex_mem.alu_out, i_wb_fwd);

   always_comb begin
      case (i_src_a_sel)
         ex_ctl_pkg::PC_TO_A:   data_a = i_pc_4;  // link
         ex_ctl_pkg::RS_TO_A:   data_a = rs_val;
         ex_ctl_pkg::SEXT_TO_A: data_a = i_sign_ext;
         default:               data_a = '0;
      endcase
   end

   assign data_b = (i_src_b_sel == ex_ctl_pkg::SEXT_TO_B) ? i_sign_ext : rt_val;

   always_comb begin
      case (i_dest_sel)
         ex_ctl_pkg::DEST_FROM_RT:   o_reg_dst = i_rt_num;
         ex_ctl_pkg::DEST_TO_RETURN: o_reg_dst = ex_data_pkg::reg_num_t'(`RETURN_REG);
         default:                    o_reg_dst = i_rd_num;
      endcase
   end

   alu_control alu_control_i (.i_alu_op(i_alu_op), .i_function(i_function), .o_sel(alu_sel));

   alu alu_i (.i_data_a(data_a), .i_data_b(data_b), .i_sel(alu_sel), .o_result(alu_out));

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ex_mem_q <= '0;
      end else if (!i_stall) begin
         ex_mem_q <= '{wb_ctl: i_wb_ctl, mem_ctl: i_mem_ctl, alu_out: alu_out,
                       store_data: rt_val, reg_dst: o_reg_dst};
      end
   end

   assign ex_mem.wb_ctl     = ex_mem_q.wb_ctl;
   assign ex_mem.mem_ctl    = ex_mem_q.mem_ctl;
   assign ex_mem.alu_out    = ex_mem_q.alu_out;
   assign ex_mem.store_data = ex_mem_q.store_data;
   assign ex_mem.reg_dst    = ex_mem_q.reg_dst;

endmodule

//--- rtl/mem_stage.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module mem_stage (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_stall,
   ex_mem_if.consumer           ex_mem,
   output ex_data_pkg::mem_wb_t o_mem_wb
);

   localparam int NB_ADDR = $clog2(`DMEM_WORDS);

   ex_data_pkg::word_t   dmem [`DMEM_WORDS];
   logic [NB_ADDR-1:0]   word_idx;
   ex_data_pkg::word_t   load_data;
   ex_data_pkg::word_t   wb_data;
   ex_data_pkg::mem_wb_t mem_wb_q;

   // byte address to word index, wraps at the depth
   assign word_idx = ex_mem.alu_out[NB_ADDR+1:2];

   // asynchronous read
   assign load_data = ex_mem.mem_ctl.mem_read ? dmem[word_idx] : '0;

   always_ff @(posedge i_clk) begin
      if (ex_mem.mem_ctl.mem_write && !i_stall) begin
         dmem[word_idx] <= ex_mem.store_data;
      end
   end

   assign wb_data = ex_mem.wb_ctl.mem_to_reg ? load_data : ex_mem.alu_out;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         mem_wb_q <= '0;
      end else if (!i_stall) begin
         mem_wb_q <= '{wb_ctl: ex_mem.wb_ctl, reg_dst: ex_mem.reg_dst, data: wb_data};
      end
   end

   assign o_mem_wb = mem_wb_q;

endmodule

//--- rtl/ex_mem_top.sv
`timescale 1ns/1ps

module ex_mem_top (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_stall,
   input  ex_ctl_pkg::alu_op_t   i_alu_op,
   input  ex_ctl_pkg::funct_t    i_function,
   input  ex_ctl_pkg::src_a_t    i_src_a_sel,
   input  ex_ctl_pkg::src_b_t    i_src_b_sel,
   input  ex_ctl_pkg::dest_t     i_dest_sel,
   input  ex_data_pkg::reg_num_t i_rs_num,
   input  ex_data_pkg::reg_num_t i_rt_num,
   input  ex_data_pkg::reg_num_t i_rd_num,
   input  ex_data_pkg::word_t    i_rs_data,
   input  ex_data_pkg::word_t    i_rt_data,
   input  ex_data_pkg::word_t    i_sign_ext,
   input  ex_data_pkg::word_t    i_pc_4,
   input  logic                  i_reg_write,
   input  logic                  i_mem_to_reg,
   input  logic                  i_mem_read,
   input  logic                  i_mem_write,
   output ex_data_pkg::reg_num_t o_ex_reg_dst,  // to the bubble unit
   output logic                  o_wb_reg_write,
   output ex_data_pkg::reg_num_t o_wb_reg_dst,
   output ex_data_pkg::word_t    o_wb_data
);

   ex_ctl_pkg::wb_ctl_t  wb_ctl;
   ex_ctl_pkg::mem_ctl_t mem_ctl;
   ex_ctl_pkg::fwd_t     fwd_a, fwd_b;
   ex_data_pkg::mem_wb_t mem_wb;

   assign wb_ctl  = '{reg_write: i_reg_write, mem_to_reg: i_mem_to_reg};
   assign mem_ctl = '{mem_read: i_mem_read, mem_write: i_mem_write};

   ex_mem_if ex_mem_bus ();

   forwarding_unit forwarding_unit_i (
      .i_rs_num(i_rs_num), .i_rt_num(i_rt_num), .ex_mem(ex_mem_bus.monitor),
      .i_mem_wb(mem_wb), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b)
   );

   ex_stage ex_stage_i (
      .i_clk(i_clk), .i_rst(i_rst), .i_stall(i_stall),
      .i_alu_op(i_alu_op), .i_function(i_function),
      .i_src_a_sel(i_src_a_sel), .i_src_b_sel(i_src_b_sel), .i_dest_sel(i_dest_sel),
      .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
      .i_rt_num(i_rt_num), .i_rd_num(i_rd_num),
      .i_rs_data(i_rs_data), .i_rt_data(i_rt_data),
      .i_sign_ext(i_sign_ext), .i_pc_4(i_pc_4),
      .i_wb_ctl(wb_ctl), .i_mem_ctl(mem_ctl), .i_wb_fwd(mem_wb.data),
      .ex_mem(ex_mem_bus.producer), .o_reg_dst(o_ex_reg_dst)
   );

   mem_stage mem_stage_i (
      .i_clk(i_clk), .i_rst(i_rst), .i_stall(i_stall),
      .ex_mem(ex_mem_bus.consumer), .o_mem_wb(mem_wb)
   );

   assign o_wb_reg_write = mem_wb.wb_ctl.reg_write;
   assign o_wb_reg_dst   = mem_wb.reg_dst;
   assign o_wb_data      = mem_wb.data;

endmodule

//--- tests/tb_ex_mem_top.sv
`timescale 1ns/1ps
`include "ex_macros.svh"

module tb_ex_mem_top;

   localparam int RST_CYCLES = 16;
   localparam int N_ITEMS    = 64;  // upper bound on issue and bubble slots

   logic i_clk = 1'b0;
   logic i_rst, i_stall;
   ex_ctl_pkg::alu_op_t   i_alu_op;
   ex_ctl_pkg::funct_t    i_function;
   ex_ctl_pkg::src_a_t    i_src_a_sel;
   ex_ctl_pkg::src_b_t    i_src_b_sel;
   ex_ctl_pkg::dest_t     i_dest_sel;
   ex_data_pkg::reg_num_t i_rs_num, i_rt_num, i_rd_num, o_ex_reg_dst, o_wb_reg_dst;
   ex_data_pkg::word_t    i_rs_data, i_rt_data, i_sign_ext, i_pc_4, o_wb_data;
   logic i_reg_write, i_mem_to_reg, i_mem_read, i_mem_write, o_wb_reg_write;

   logic   in_valid, v1, wb_new;  // which pipeline slots carry real items
   integer seed = 32'hb2636d32;
   int     mismatches = 0;
   int     failures = 0;

   ex_data_pkg::word_t rf [32];     // registers in program order
   ex_data_pkg::word_t rf_wb [32];  // register file as decode would read it
   ex_data_pkg::word_t dmem [`DMEM_WORDS];

   logic                  exp_rw [$];
   ex_data_pkg::reg_num_t exp_dst [$];
   ex_data_pkg::word_t    exp_data [$];
   string                 exp_name [$];

   ex_mem_top ex_mem_top_i (.*);

   always #10 i_clk = ~i_clk;

   // follows items through the two registers, frozen by stall
   always @(posedge i_clk) begin
      if (i_rst) begin
         v1     <= 1'b0;
         wb_new <= 1'b0;
      end else if (!i_stall) begin
         v1     <= in_valid;
         wb_new <= v1;
      end else begin
         wb_new <= 1'b0;
      end
   end

   always @(negedge i_clk) begin
      if (wb_new) retire_item();
   end

   task automatic compare_word(input string name, input ex_data_pkg::word_t exp_val,
                               input ex_data_pkg::word_t act_val);
      if (act_val !== exp_val) begin
         mismatches++;
         $display("MISMATCH %s: expected %h, actual %h", name, exp_val, act_val);
      end
   endtask

   task automatic compare_reg(input string name, input ex_data_pkg::reg_num_t exp_val,
                              input ex_data_pkg::reg_num_t act_val);
      if (act_val !== exp_val) begin
         mismatches++;
         $display("MISMATCH %s: expected r%0d, actual r%0d", name, exp_val, act_val);
      end
   endtask

   task automatic compare_flag(input string name, input logic exp_val, input logic act_val);
      if (act_val !== exp_val) begin
         mismatches++;
         $display("MISMATCH %s: expected %b, actual %b", name, exp_val, act_val);
      end
   endtask

   task automatic retire_item();
      string                 name;
      logic                  rw;
      ex_data_pkg::reg_num_t dst;
      ex_data_pkg::word_t    data;
      if (exp_rw.size() == 0) begin
         failures++;
         $display("a write-back slot reached the outputs with no item expected");
         return;
      end
      name = exp_name.pop_front();
      rw   = exp_rw.pop_front();
      dst  = exp_dst.pop_front();
      data = exp_data.pop_front();
      compare_flag(name, rw, o_wb_reg_write);
      if (rw) begin
         compare_reg(name, dst, o_wb_reg_dst);
         compare_word(name, data, o_wb_data);
         if (dst != '0) rf_wb[dst] = data;
      end
   endtask

   function automatic ex_data_pkg::word_t model_alu(input ex_ctl_pkg::alu_op_t op,
         input ex_ctl_pkg::funct_t fn, input ex_data_pkg::word_t a, input ex_data_pkg::word_t b);
      case (op)
         ex_ctl_pkg::ALUOP_SUB: return a - b;
         ex_ctl_pkg::ALUOP_AND: return a & b;
         ex_ctl_pkg::ALUOP_OR:  return a | b;
         ex_ctl_pkg::ALUOP_XOR: return a ^ b;
         ex_ctl_pkg::ALUOP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         ex_ctl_pkg::ALUOP_LUI: return {b[15:0], 16'h0000};
         ex_ctl_pkg::ALUOP_RTYPE: begin
            case (fn)
               ex_ctl_pkg::FN_SLL: return b << a[4:0];
               ex_ctl_pkg::FN_SRL: return b >> a[4:0];
               ex_ctl_pkg::FN_SRA: return $signed(b) >>> a[4:0];
               ex_ctl_pkg::FN_SUB: return a - b;
               ex_ctl_pkg::FN_AND: return a & b;
               ex_ctl_pkg::FN_OR:  return a | b;
               ex_ctl_pkg::FN_XOR: return a ^ b;
               ex_ctl_pkg::FN_NOR: return ~(a | b);
               ex_ctl_pkg::FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default:            return a + b;
            endcase
         end
         default: return a + b;
      endcase
   endfunction

   function automatic ex_data_pkg::reg_num_t rnd_reg();
      return ex_data_pkg::reg_num_t'({$random(seed)} % 30 + 1);
   endfunction

   // model computes the result in program order, ports carry decode-time data
   task automatic issue(input string name, input ex_ctl_pkg::alu_op_t op,
                        input ex_ctl_pkg::funct_t fn, input ex_ctl_pkg::src_a_t sa,
                        input ex_ctl_pkg::src_b_t sb, input ex_ctl_pkg::dest_t ds,
                        input ex_data_pkg::reg_num_t rs, rt, rd,
                        input ex_data_pkg::word_t imm, input logic rw, m2r, mr, mw);
      ex_data_pkg::word_t    pc4, a, b, res, data;
      ex_data_pkg::reg_num_t dst;
      pc4 = $random(seed) & 32'hffff_fffc;
      a = (sa == ex_ctl_pkg::PC_TO_A) ? pc4 : (sa == ex_ctl_pkg::RS_TO_A) ? rf[rs] : imm;
      b = (sb == ex_ctl_pkg::SEXT_TO_B) ? imm : rf[rt];
      dst = (ds == ex_ctl_pkg::DEST_FROM_RT) ? rt :
            (ds == ex_ctl_pkg::DEST_TO_RETURN) ? ex_data_pkg::reg_num_t'(`RETURN_REG) : rd;
      res  = model_alu(op, fn, a, b);
      data = (mr && m2r) ? dmem[(res >> 2) % `DMEM_WORDS] : res;
      if (mw) dmem[(res >> 2) % `DMEM_WORDS] = rf[rt];
      if (rw && dst != '0) rf[dst] = data;
      exp_name.push_back(name);
      exp_rw.push_back(rw);
      exp_dst.push_back(dst);
      exp_data.push_back(data);
      @(posedge i_clk);
      i_alu_op     <= op;
      i_function   <= fn;
      i_src_a_sel  <= sa;
      i_src_b_sel  <= sb;
      i_dest_sel   <= ds;
      i_rs_num     <= rs;
      i_rt_num     <= rt;
      i_rd_num     <= rd;
      i_rs_data    <= rf_wb[rs];  // stale while a write is in flight
      i_rt_data    <= rf_wb[rt];
      i_sign_ext   <= imm;
      i_pc_4       <= pc4;
      i_reg_write  <= rw;
      i_mem_to_reg <= m2r;
      i_mem_read   <= mr;
      i_mem_write  <= mw;
      in_valid     <= 1'b1;
      @(negedge i_clk);
      compare_reg({name, " ex dst"}, dst, o_ex_reg_dst);
   endtask

   task automatic alu_rr(input string name, input ex_ctl_pkg::alu_op_t op,
                         input ex_ctl_pkg::funct_t fn, input ex_data_pkg::reg_num_t rs, rt, rd);
      issue(name, op, fn, ex_ctl_pkg::RS_TO_A, ex_ctl_pkg::RT_TO_B, ex_ctl_pkg::DEST_FROM_RD,
            rs, rt, rd, '0, 1'b1, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic alu_ri(input string name, input ex_ctl_pkg::alu_op_t op,
                         input ex_data_pkg::reg_num_t rs, rt, input ex_data_pkg::word_t imm);
      issue(name, op, ex_ctl_pkg::FN_ADD, ex_ctl_pkg::RS_TO_A, ex_ctl_pkg::SEXT_TO_B,
            ex_ctl_pkg::DEST_FROM_RT, rs, rt, 5'd0, imm, 1'b1, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic mem_access(input string name, input ex_data_pkg::reg_num_t base, rt,
                             input ex_data_pkg::word_t offset, input logic load);
      issue(name, ex_ctl_pkg::ALUOP_ADD, ex_ctl_pkg::FN_ADD, ex_ctl_pkg::RS_TO_A,
            ex_ctl_pkg::SEXT_TO_B, ex_ctl_pkg::DEST_FROM_RT, base, rt, 5'd0, offset,
            load, load, load, !load);
   endtask

   task automatic bubble(input int n);
      repeat (n) begin
         @(posedge i_clk);
         i_reg_write <= 1'b0;
         i_mem_read  <= 1'b0;
         i_mem_write <= 1'b0;
         in_valid    <= 1'b0;
      end
   endtask

   task automatic reset_outputs();
      @(negedge i_clk);
      compare_flag("reset", 1'b0, o_wb_reg_write);
      compare_word("reset", '0, o_wb_data);
   endtask

   task automatic alu_operations();
      ex_ctl_pkg::funct_t fns [10] = '{ex_ctl_pkg::FN_SLL, ex_ctl_pkg::FN_SRL,
         ex_ctl_pkg::FN_SRA, ex_ctl_pkg::FN_ADD, ex_ctl_pkg::FN_SUB, ex_ctl_pkg::FN_AND,
         ex_ctl_pkg::FN_OR, ex_ctl_pkg::FN_XOR, ex_ctl_pkg::FN_NOR, ex_ctl_pkg::FN_SLT};
      ex_ctl_pkg::alu_op_t ops [5] = '{ex_ctl_pkg::ALUOP_SUB, ex_ctl_pkg::ALUOP_AND,
         ex_ctl_pkg::ALUOP_OR, ex_ctl_pkg::ALUOP_XOR, ex_ctl_pkg::ALUOP_SLT};
      foreach (fns[i])
         alu_rr($sformatf("rtype fn %0d", fns[i]), ex_ctl_pkg::ALUOP_RTYPE, fns[i],
                rnd_reg(), rnd_reg(), rnd_reg());
      foreach (ops[i])
         alu_rr($sformatf("class %0d", ops[i]), ops[i], ex_ctl_pkg::FN_ADD,
                rnd_reg(), rnd_reg(), rnd_reg());
      alu_ri("addi neg", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd3, 32'hffff_fffb);
      alu_ri("addi pos", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd4, 32'd7);
      alu_rr("slt neg", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_SLT, 5'd3, 5'd4, 5'd5);
      alu_rr("slt class", ex_ctl_pkg::ALUOP_SLT, ex_ctl_pkg::FN_ADD, 5'd4, 5'd3, 5'd6);
      alu_ri("lui", ex_ctl_pkg::ALUOP_LUI, 5'd0, 5'd7, 32'h0000_1234);
      alu_ri("shamt", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd8, 32'd35);  // low bits give 3
      alu_rr("sra neg", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_SRA, 5'd8, 5'd3, 5'd9);
      alu_rr("srl neg", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_SRL, 5'd8, 5'd3, 5'd10);
      alu_rr("sll", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_SLL, 5'd8, 5'd4, 5'd11);
   endtask

   task automatic link_return();
      issue("link", ex_ctl_pkg::ALUOP_ADD, ex_ctl_pkg::FN_ADD, ex_ctl_pkg::PC_TO_A,
            ex_ctl_pkg::SEXT_TO_B, ex_ctl_pkg::DEST_TO_RETURN, 5'd0, 5'd0, 5'd0, '0,
            1'b1, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic forward_chain();
      alu_ri("fwd src", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd12, 32'd100);
      alu_rr("fwd ex/mem", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_ADD, 5'd12, 5'd12, 5'd13);
      alu_ri("fwd far", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd14, 32'd200);
      alu_ri("fwd near", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd15, 32'd5);
      alu_rr("fwd mem/wb", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_SUB, 5'd14, 5'd15, 5'd16);
      alu_ri("fwd old", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd17, 32'd1);
      alu_ri("fwd new", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd17, 32'd2);
      alu_rr("fwd newest", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_OR, 5'd17, 5'd17, 5'd18);
      alu_rr("write r0", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_ADD, 5'd12, 5'd12, 5'd0);
      alu_rr("read r0", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_ADD, 5'd0, 5'd0, 5'd19);
      alu_rr("read r0 late", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_ADD, 5'd0, 5'd0, 5'd27);
   endtask

   task automatic store_then_load();
      alu_ri("base", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd20, 32'h40);
      alu_ri("store val", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd21, $random(seed));
      mem_access("store", 5'd20, 5'd21, 32'd8, 1'b0);  // store data via ex/mem
      mem_access("load", 5'd20, 5'd22, 32'd8, 1'b1);
      bubble(1);
      alu_rr("use load", ex_ctl_pkg::ALUOP_RTYPE, ex_ctl_pkg::FN_ADD, 5'd22, 5'd0, 5'd23);
   endtask

   task automatic stall_and_release(input int n);
      ex_data_pkg::word_t held_data;
      alu_ri("stall val", ex_ctl_pkg::ALUOP_ADD, 5'd0, 5'd24, $random(seed));
      held_data = rf[24];  // sits in mem/wb during the stall
      mem_access("stall store", 5'd20, 5'd24, 32'd12, 1'b0);
      bubble(1);
      i_stall <= 1'b1;  // store now waits in ex/mem
      repeat (n) begin
         @(negedge i_clk);
         compare_flag("stall hold", 1'b1, o_wb_reg_write);
         compare_reg("stall hold", 5'd24, o_wb_reg_dst);
         compare_word("stall hold", held_data, o_wb_data);
      end
      @(posedge i_clk);
      i_stall <= 1'b0;
      mem_access("stall load", 5'd20, 5'd25, 32'd12, 1'b1);
      alu_ri("after stall", ex_ctl_pkg::ALUOP_XOR, 5'd24, 5'd26, 32'h0000_00ff);
   endtask

   initial begin
      i_rst <= 1'b1;
      i_stall <= 1'b0;
      i_alu_op <= ex_ctl_pkg::ALUOP_ADD;
      i_function <= ex_ctl_pkg::FN_ADD;
      i_src_a_sel <= ex_ctl_pkg::RS_TO_A;
      i_src_b_sel <= ex_ctl_pkg::RT_TO_B;
      i_dest_sel <= ex_ctl_pkg::DEST_FROM_RD;
      i_rs_num <= '0;
      i_rt_num <= '0;
      i_rd_num <= '0;
      i_rs_data <= '0;
      i_rt_data <= '0;
      i_sign_ext <= '0;
      i_pc_4 <= '0;
      i_reg_write <= 1'b0;
      i_mem_to_reg <= 1'b0;
      i_mem_read <= 1'b0;
      i_mem_write <= 1'b0;
      in_valid <= 1'b0;
      for (int r = 0; r < 32; r++) begin
         rf[r] = (r == 0) ? '0 : $random(seed);
         rf_wb[r] = rf[r];
      end
      repeat (RST_CYCLES) @(posedge i_clk);
      i_rst <= 1'b0;
      reset_outputs();
      alu_operations();
      link_return();
      forward_chain();
      store_then_load();
      stall_and_release(5);
      bubble(3);  // drain
      if (exp_rw.size() != 0) begin
         failures++;
         $display("%0d items never reached write-back", exp_rw.size());
      end
      $display("mismatches %0d, other failures %0d", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // watchdog
   initial begin
      #((RST_CYCLES + 40 * N_ITEMS) * 20);
      $display("timeout: the tests did not finish in the allowed time");
      $display("TB FAILED");
      $finish;
   end

endmodule

//--- ex_mem_top.f
+incdir+include
rtl/ex_ctl_pkg.sv
rtl/ex_data_pkg.sv
rtl/ex_mem_if.sv
rtl/alu.sv
rtl/alu_control.sv
rtl/forwarding_unit.sv
rtl/ex_stage.sv
rtl/mem_stage.sv
rtl/ex_mem_top.sv
tests/tb_ex_mem_top.sv

//--- Bender.yml
package:
  name: ex_mem_top

sources:
  - include_dirs:
      - include
    files:
      - rtl/ex_ctl_pkg.sv
      - rtl/ex_data_pkg.sv
      - rtl/ex_mem_if.sv
      - rtl/alu.sv
      - rtl/alu_control.sv
      - rtl/forwarding_unit.sv
      - rtl/ex_stage.sv
      - rtl/mem_stage.sv
      - rtl/ex_mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_ex_mem_top.sv
